// ==== Bender.yml ====
package:
  name: vga_mem_read

sources:
  - logic/vga_pkg.sv
  - logic/vga_gfx_regs.sv
  - logic/vga_read_iface.sv
  - logic/vga_plane_sram.sv
  - logic/vga_mem_read_top.sv
  - target: test
    files:
      - bench/vga_read_chk.sv
      - bench/vga_read_tb.sv

// ==== bench/vga_read_chk.sv ====
//####################################################################
// Protocol checks on the read interface master bus
// Bound into every vga_read_iface instance
//####################################################################

`timescale 1ns/1ps

module vga_read_chk (
  input logic        wb_clk_i,
  input logic        wb_rst_i,
  input logic        cpu_ack_o,
  input logic        wbm_stb_o,
  input logic        wbm_ack_i,
  input logic [17:1] wbm_adr_o
);

  // Set once any property below has failed
  logic err_seen = 1'b0;

  // CPU ack only inside a master cycle
  a_ack_in_burst: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    cpu_ack_o |-> wbm_stb_o)
    else begin
      $error("cpu_ack_o high while wbm_stb_o is low");
      err_seen = 1'b1;
    end

  // Plane select held until the SRAM acks
  a_plane_stable: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    (wbm_stb_o && !wbm_ack_i) |=> $stable(wbm_adr_o[17:16]))
    else begin
      $error("plane bits of wbm_adr_o changed before wbm_ack_i");
      err_seen = 1'b1;
    end

  // Burst ends right after the CPU ack
  a_stb_drop: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    cpu_ack_o |=> !wbm_stb_o)
    else begin
      $error("wbm_stb_o still high in the cycle after cpu_ack_o");
      err_seen = 1'b1;
    end

endmodule

bind vga_read_iface vga_read_chk u_chk (
  .wb_clk_i  (wb_clk_i),
  .wb_rst_i  (wb_rst_i),
  .cpu_ack_o (cpu_ack_o),
  .wbm_stb_o (wbm_stb_o),
  .wbm_ack_i (wbm_ack_i),
  .wbm_adr_o (wbm_adr_o)
);

// ==== bench/vga_read_tb.sv ====
//####################################################################
// Testbench for the VGA memory read path
// Replays preloads, register writes and CPU reads from the test file
// and compares read data and latch bytes with the expected values
//####################################################################

`timescale 1ns/1ps

module vga_read_tb;

  import vga_pkg::*;

  localparam int ACK_TIMEOUT  = 50;
  localparam int RESET_CYCLES = 10;

  logic        wb_clk;
  logic        wb_rst;
  logic        reg_we;
  logic [3:0]  reg_idx;
  logic [7:0]  reg_dat;
  cpu_rd_req_t cpu_req;
  logic [15:0] cpu_dat;
  logic        cpu_ack;
  sram_ld_t    ld;
  vga_latch_t  latch;

  int n_reads  = 0;

  vga_mem_read_top #(
    .OFFSET_AW (15)
  ) dut (
    .wb_clk_i  (wb_clk),
    .wb_rst_i  (wb_rst),
    .reg_we_i  (reg_we),
    .reg_idx_i (reg_idx),
    .reg_dat_i (reg_dat),
    .cpu_req_i (cpu_req),
    .cpu_dat_o (cpu_dat),
    .cpu_ack_o (cpu_ack),
    .ld_i      (ld),
    .latch_o   (latch)
  );

  // 4 ns clock
  initial wb_clk = 1'b0;
  always #2 wb_clk = ~wb_clk;

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "simulation stopped");
  endtask

  // Bound master bus checks end the run at the next edge
  always @(posedge wb_clk)
  begin
    if (dut.u_read.u_chk.err_seen)
      stop_run("A protocol assertion on the read interface master bus failed");
  end

  // Ops start and end 1 ns after a rising edge
  task automatic preload_word(input logic [1:0] plane, input logic [14:0] ofs,
                              input logic [15:0] dat);
    ld.we  = 1'b1;
    ld.adr = {plane, ofs};
    ld.dat = dat;
    @(posedge wb_clk);
    #1;
    ld.we = 1'b0;
  endtask

  task automatic write_reg(input logic [3:0] idx, input logic [7:0] dat);
    reg_we  = 1'b1;
    reg_idx = idx;
    reg_dat = dat;
    @(posedge wb_clk);
    #1;
    reg_we = 1'b0;
  endtask

  task automatic run_read(input string name, input logic [15:0] adr, input logic [1:0] sel,
                          input logic [15:0] exp_dat, input logic [31:0] exp_latch);
    int cycles;
    cpu_req.adr = adr;
    cpu_req.sel = sel;
    cpu_req.stb = 1'b1;
    cycles = 0;
    // Strobe held until the fourth plane ack
    while (!cpu_ack && cycles < ACK_TIMEOUT)
    begin
      @(posedge wb_clk);
      #1;
      cycles++;
    end
    if (!cpu_ack)
      stop_run($sformatf("Read %s got no cpu_ack_o within %0d cycles", name, ACK_TIMEOUT));
    n_reads++;
    assert (cpu_dat === exp_dat)
    else
      stop_run($sformatf("[ERROR] %s: cpu_dat_o expected %h actual %h", name, exp_dat, cpu_dat));
    @(posedge wb_clk);
    #1;
    cpu_req.stb = 1'b0;
    // Latches settle one cycle after the strobe drops
    @(posedge wb_clk);
    #1;
    assert (latch === exp_latch)
    else
      stop_run($sformatf("[ERROR] %s: latch_o expected %h actual %h", name, exp_latch, latch));
  endtask

  initial
  begin : replay
    int          fd;
    int          line_no;
    string       line;
    string       op;
    string       name;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    logic [31:0] d;
    reg_we  = 1'b0;
    reg_idx = 4'h0;
    reg_dat = 8'h00;
    cpu_req = '0;
    ld      = '0;
    line_no = 0;
    wb_rst  = 1'b1;
    for (int i = 0; i < RESET_CYCLES; i++)
      @(posedge wb_clk);
    #1;
    wb_rst = 1'b0;
    fd = $fopen("bench/vga_read_tests.txt", "r");
    if (fd == 0)
      stop_run("Could not open the test file bench/vga_read_tests.txt");
    while (!$feof(fd))
    begin
      line = "";
      void'($fgets(line, fd));
      line_no++;
      // Skip comments and blank lines
      if (line.len() == 0 || line[0] == "#" || $sscanf(line, "%s", op) != 1)
        continue;
      if (op == "L")
      begin
        if ($sscanf(line, "%s %h %h %h", op, a, b, c) != 4)
          stop_run($sformatf("Malformed preload on line %0d of the test file", line_no));
        preload_word(a[1:0], b[14:0], c[15:0]);
      end
      else if (op == "W")
      begin
        if ($sscanf(line, "%s %h %h", op, a, b) != 3)
          stop_run($sformatf("Malformed register write on line %0d", line_no));
        write_reg(a[3:0], b[7:0]);
      end
      else if (op == "R")
      begin
        if ($sscanf(line, "%s %s %h %h %h %h", op, name, a, b, c, d) != 6)
          stop_run($sformatf("Malformed read on line %0d of the test file", line_no));
        run_read(name, a[15:0], b[1:0], c[15:0], d);
      end
      else
        stop_run($sformatf("Unknown operation %s on line %0d", op, line_no));
    end
    $fclose(fd);
    @(posedge wb_clk);
    #1;
    if (n_reads > 0 && !dut.u_read.u_chk.err_seen)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

endmodule

// ==== bench/vga_read_tests.txt ====
# L plane offset data | W index data | R name adr sel exp_dat exp_latch
# All fields hex, exp_latch holds lat0 in the top byte down to lat3
L 0 0010 12A5
L 1 0010 34C3
L 2 0010 560F
L 3 0010 78F0
L 0 4010 9A11
L 1 4010 BC22
L 2 4010 DE44
L 3 4010 F088
R reset_map0 0010 1 12A5 A5C30FF0
W 4 01
R map1_lo 0010 1 34C3 A5C30FF0
W 4 02
R map2_hi 0010 2 560F 12345678
W 4 03
R map3_far 4010 3 F088 9ABCDEF0
W 4 00
W 6 04
R win64k_near 0010 1 12A5 A5C30FF0
R win64k_far 4010 1 12A5 A5C30FF0
W 6 0C
R map3mode_far 4010 1 9A11 11224488
W 0 FF
W 3 FF
R unused_idx 4010 1 9A11 11224488
W 5 08
R cmp_dc_none 0010 1 FFFF A5C30FF0
W 2 05
W 7 0F
R cmp_all 0010 2 0204 12345678
W 7 03
R cmp_p01 0010 1 0224 A5C30FF0

// ==== logic/vga_gfx_regs.sv ====
//####################################################################
// Graphics controller register file for the read path
// Index/data writes with a one-cycle strobe update the read config
//####################################################################

`timescale 1ns/1ps

module vga_gfx_regs (
  input  logic                 wb_clk_i,
  input  logic                 wb_rst_i,
  input  logic                 reg_we_i,
  input  logic [3:0]           reg_idx_i,
  input  logic [7:0]           reg_dat_i,
  output vga_pkg::vga_rd_cfg_t cfg_o
);

  import vga_pkg::*;

  // Decoded register index
  gfx_reg_e   reg_idx;

  // Stored register fields
  logic [3:0] color_compare_q;
  logic [1:0] read_map_q;
  logic       read_mode_q;
  logic [1:0] memory_map_q;
  logic [3:0] dont_care_q;

  assign reg_idx = gfx_reg_e'(reg_idx_i);

  // Only the addressed field changes
  always_ff @(posedge wb_clk_i)
  begin
    if (wb_rst_i)
    begin
      color_compare_q <= 4'h0;
      read_map_q      <= 2'b00;
      read_mode_q     <= 1'b0;
      memory_map_q    <= 2'b00;
      dont_care_q     <= 4'h0;
    end
    else if (reg_we_i)
    begin
      case (reg_idx)
        GFX_COLOR_COMPARE: color_compare_q <= reg_dat_i[3:0];
        GFX_READ_MAP:      read_map_q      <= reg_dat_i[1:0];
        GFX_MODE:          read_mode_q     <= reg_dat_i[3];
        GFX_MISC:          memory_map_q    <= reg_dat_i[3:2];
        GFX_DONT_CARE:     dont_care_q     <= reg_dat_i[3:0];
        // Unused index, write dropped
        default: ;
      endcase
    end
  end

  // Map field 1 selects the A0000 64 KB window
  assign cfg_o.memory_mapping1 = (memory_map_q == 2'b01);
  assign cfg_o.read_mode       = read_mode_q;
  assign cfg_o.read_map_select = read_map_q;
  assign cfg_o.color_compare   = color_compare_q;
  assign cfg_o.color_dont_care = dont_care_q;

endmodule

// ==== logic/vga_mem_read_top.sv ====
//####################################################################
// Top level of the VGA memory read path
// Graphics registers configure the read interface, which bursts
// plane reads from the SRAM and exports the latch bytes
//####################################################################

`timescale 1ns/1ps

module vga_mem_read_top #(
  parameter int OFFSET_AW = 15
) (
  input  logic                 wb_clk_i,
  input  logic                 wb_rst_i,
  // Graphics register port
  input  logic                 reg_we_i,
  input  logic [3:0]           reg_idx_i,
  input  logic [7:0]           reg_dat_i,
  // CPU read
  input  vga_pkg::cpu_rd_req_t cpu_req_i,
  output logic [15:0]          cpu_dat_o,
  output logic                 cpu_ack_o,
  // SRAM preload
  input  vga_pkg::sram_ld_t    ld_i,
  // Latches toward the write path
  output vga_pkg::vga_latch_t  latch_o
);

  import vga_pkg::*;

  vga_rd_cfg_t cfg;

  // Master bus to the SRAM
  logic [17:1] wbm_adr;
  logic [15:0] wbm_dat;
  logic        wbm_stb;
  logic        wbm_ack;

  vga_gfx_regs u_regs (
    .wb_clk_i  (wb_clk_i),
    .wb_rst_i  (wb_rst_i),
    .reg_we_i  (reg_we_i),
    .reg_idx_i (reg_idx_i),
    .reg_dat_i (reg_dat_i),
    .cfg_o     (cfg)
  );

  vga_read_iface u_read (
    .wb_clk_i  (wb_clk_i),
    .wb_rst_i  (wb_rst_i),
    .cpu_req_i (cpu_req_i),
    .cpu_dat_o (cpu_dat_o),
    .cpu_ack_o (cpu_ack_o),
    .wbm_adr_o (wbm_adr),
    .wbm_dat_i (wbm_dat),
    .wbm_stb_o (wbm_stb),
    .wbm_ack_i (wbm_ack),
    .cfg_i     (cfg),
    .latch_o   (latch_o)
  );

  vga_plane_sram #(
    .OFFSET_AW (OFFSET_AW)
  ) u_sram (
    .wb_clk_i  (wb_clk_i),
    .wb_rst_i  (wb_rst_i),
    .wbs_adr_i (wbm_adr),
    .wbs_stb_i (wbm_stb),
    .wbs_dat_o (wbm_dat),
    .wbs_ack_o (wbm_ack),
    .ld_i      (ld_i)
  );

endmodule

// ==== logic/vga_pkg.sv ====
//####################################################################
// Shared types of the VGA memory read path
// Read configuration, CPU request, latch bytes, SRAM preload and
// graphics controller register indices
//####################################################################

package vga_pkg;

  // Read configuration, registers to read interface
  typedef struct packed {
    // Memory map field equals 1, 64 KB window
    logic       memory_mapping1;
    logic       read_mode;
    logic [1:0] read_map_select;
    logic [3:0] color_compare;
    logic [3:0] color_dont_care;
  } vga_rd_cfg_t;

  // Graphics controller register indices
  // Other indices are ignored on write
  typedef enum logic [3:0] {
    GFX_COLOR_COMPARE = 4'd2,
    GFX_READ_MAP      = 4'd4,
    // Read mode in bit 3
    GFX_MODE          = 4'd5,
    // Memory map in bits 3:2
    GFX_MISC          = 4'd6,
    GFX_DONT_CARE     = 4'd7
  } gfx_reg_e;

  // CPU side Wishbone read request
  typedef struct packed {
    // Word address
    logic [16:1] adr;
    logic [1:0]  sel;
    logic        stb;
  } cpu_rd_req_t;

  // Exported latch bytes, one per plane
  typedef struct packed {
    logic [7:0] lat0;
    logic [7:0] lat1;
    logic [7:0] lat2;
    logic [7:0] lat3;
  } vga_latch_t;

  // SRAM preload write, plane in adr[17:16]
  typedef struct packed {
    logic        we;
    logic [17:1] adr;
    logic [15:0] dat;
  } sram_ld_t;

endpackage

// ==== logic/vga_plane_sram.sv ====
//####################################################################
// Plane organized word SRAM model with fixed read latency
// Wishbone read slave plus a preload port for filling the planes
//####################################################################

`timescale 1ns/1ps

module vga_plane_sram #(
  parameter int OFFSET_AW = 15
) (
  input  logic              wb_clk_i,
  input  logic              wb_rst_i,
  // Read slave, plane in adr[17:16]
  input  logic [17:1]       wbs_adr_i,
  input  logic              wbs_stb_i,
  output logic [15:0]       wbs_dat_o,
  output logic              wbs_ack_o,
  // Preload write
  input  vga_pkg::sram_ld_t ld_i
);

  // Four planes of 2^OFFSET_AW words
  localparam int DEPTH = 4 << OFFSET_AW;

  logic [15:0]          mem [DEPTH];
  logic [OFFSET_AW+1:0] rd_idx;
  logic [OFFSET_AW+1:0] ld_idx;

  // Offset above OFFSET_AW bits wraps
  assign rd_idx = {wbs_adr_i[17:16], wbs_adr_i[OFFSET_AW:1]};
  assign ld_idx = {ld_i.adr[17:16], ld_i.adr[OFFSET_AW:1]};

  // Ack pulses, so a held strobe sees every other cycle
  always_ff @(posedge wb_clk_i)
  begin
    if (wb_rst_i)
      wbs_ack_o <= 1'b0;
    else
      wbs_ack_o <= wbs_stb_i && !wbs_ack_o;
  end

  // Registered read data, valid with ack
  always_ff @(posedge wb_clk_i)
  begin
    if (wbs_stb_i && !wbs_ack_o)
      wbs_dat_o <= mem[rd_idx];
  end

  // One preload word per write strobe
  always_ff @(posedge wb_clk_i)
  begin
    if (ld_i.we)
      mem[ld_idx] <= ld_i.dat;
  end

endmodule

// ==== logic/vga_read_iface.sv ====
//####################################################################
// CPU read interface of the planar video memory
// One CPU word read runs four plane reads, fills the latches and
// returns read mode 0 or read mode 1 data with the last plane ack
//####################################################################

`timescale 1ns/1ps

module vga_read_iface (
  input  logic                 wb_clk_i,
  input  logic                 wb_rst_i,
  // CPU read slave
  input  vga_pkg::cpu_rd_req_t cpu_req_i,
  output logic [15:0]          cpu_dat_o,
  output logic                 cpu_ack_o,
  // Master read to plane SRAM
  output logic [17:1]          wbm_adr_o,
  input  logic [15:0]          wbm_dat_i,
  output logic                 wbm_stb_o,
  input  logic                 wbm_ack_i,
  // Configuration and latch export
  input  vga_pkg::vga_rd_cfg_t cfg_i,
  output vga_pkg::vga_latch_t  latch_o
);

  // Current plane of the burst
  logic [1:0]  plane_q;
  // High byte select from the last request
  logic        latch_sel_q;
  // Full plane words of the last read
  logic [15:0] latch_q [4];

  logic [15:1] offset;
  logic [15:0] dat_mode0;
  logic [15:0] dat_mode1;
  logic        cont;

  // 64 KB window ignores address bit 15
  assign offset = cfg_i.memory_mapping1 ? {1'b0, cpu_req_i.adr[14:1]}
                                        : cpu_req_i.adr[15:1];

  assign wbm_adr_o = {plane_q, offset};

  // Fourth plane ack ends the CPU cycle
  assign cpu_ack_o = (plane_q == 2'd3) && wbm_ack_i;
  assign cont      = wbm_ack_i && cpu_req_i.stb;

  // Plane 3 is not latched yet, take it live from the SRAM
  assign dat_mode0 = (cfg_i.read_map_select == 2'd3) ? wbm_dat_i
                                                     : latch_q[cfg_i.read_map_select];

  // Colour compare over all four planes
  always_comb
  begin : color_cmp
    logic [15:0] diff_acc;
    logic [15:0] plane_w;
    diff_acc = '0;
    for (int p = 0; p < 4; p++)
    begin
      plane_w  = (p == 3) ? wbm_dat_i : latch_q[p];
      // Mismatching bits of planes that are cared about
      diff_acc = diff_acc
               | ((plane_w ^ {16{cfg_i.color_compare[p]}}) & {16{cfg_i.color_dont_care[p]}});
    end
    dat_mode1 = ~diff_acc;
  end

  assign cpu_dat_o = cfg_i.read_mode ? dat_mode1 : dat_mode0;

  // Byte lane choice for the exported latches
  always_ff @(posedge wb_clk_i)
  begin
    if (wb_rst_i)
      latch_sel_q <= 1'b0;
    else if (cpu_req_i.stb)
      latch_sel_q <= cpu_req_i.sel[1];
  end

  // Master strobe, starts after CPU strobe and drops after CPU ack
  always_ff @(posedge wb_clk_i)
  begin
    if (wb_rst_i)
      wbm_stb_o <= 1'b0;
    else
      wbm_stb_o <= wbm_stb_o ? ~cpu_ack_o : cpu_req_i.stb;
  end

  // Plane counter, wraps to 0 after plane 3
  always_ff @(posedge wb_clk_i)
  begin
    if (wb_rst_i)
      plane_q <= 2'd0;
    else if (cont)
      plane_q <= plane_q + 2'd1;
  end

  // Latch load on every acked plane
  always_ff @(posedge wb_clk_i)
  begin
    if (wb_rst_i)
    begin
      for (int p = 0; p < 4; p++)
        latch_q[p] <= 16'h0000;
    end
    else if (wbm_ack_i && wbm_stb_o)
      latch_q[plane_q] <= wbm_dat_i;
  end

  assign latch_o.lat0 = latch_sel_q ? latch_q[0][15:8] : latch_q[0][7:0];
  assign latch_o.lat1 = latch_sel_q ? latch_q[1][15:8] : latch_q[1][7:0];
  assign latch_o.lat2 = latch_sel_q ? latch_q[2][15:8] : latch_q[2][7:0];
  assign latch_o.lat3 = latch_sel_q ? latch_q[3][15:8] : latch_q[3][7:0];

endmodule

// ==== vlog.f ====
logic/vga_pkg.sv
logic/vga_gfx_regs.sv
logic/vga_read_iface.sv
logic/vga_plane_sram.sv
logic/vga_mem_read_top.sv
bench/vga_read_chk.sv
bench/vga_read_tb.sv
